// File: Bender.yml
package:
  name: sump_ctrl

sources:
  - hw/sump_pkg.sv
  - hw/sump_cmd_fsm.sv
  - hw/sump_indec.sv
  - hw/sump_cfg_regs.sv
  - hw/sump_rate_timer.sv
  - hw/sump_capture.sv
  - hw/sump_ctrl.sv
  - target: test
    files:
      - bench/sump_ctrl_tb.sv

// File: bench/sump_ctrl_tb.sv
`timescale 1ns/1ps
module sump_ctrl_tb;

  logic        clk_i;
  logic        rst_i;
  logic [7:0]  byte_i;
  logic        byte_stb_i;
  logic [31:0] probe_i;
  logic [31:0] dat_o;
  logic        vld_o;
  logic        armed_o;
  logic        trig_o;

  int          cycle;         // posedges since start
  int          limit;         // zero until the golden file is counted
  int          errors;
  int          test_errs;
  int          n_tests;
  int          n_failed;
  int          base;          // first word of the current test in got_q
  int          gap_exp;       // 0 leaves spacing unchecked
  int          trig_exp;      // -1 leaves trig_o unchecked
  string       test_name;
  logic [31:0] got_q[$];
  int          got_cyc_q[$];
  logic [31:0] exp_q[$];
  bit          trig_seen;
  logic        trig_prev;
  bit          armed_seen;
  bit          run_sent;      // a RUN opcode went out in this test

  sump_ctrl sump_ctrl_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .byte_i     (byte_i),
    .byte_stb_i (byte_stb_i),
    .probe_i    (probe_i),
    .dat_o      (dat_o),
    .vld_o      (vld_o),
    .armed_o    (armed_o),
    .trig_o     (trig_o)
  );

  initial begin : clock
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // output words and trigger edges as sampled before the edge update
  always @(posedge clk_i) begin : monitor
    cycle = cycle + 1;
    if (!rst_i && vld_o) begin
      got_q.push_back(dat_o);
      got_cyc_q.push_back(cycle);
    end
    if (trig_o === 1'b1 && trig_prev !== 1'b1) trig_seen = 1'b1;
    trig_prev = trig_o;
    if (armed_o === 1'b1) armed_seen = 1'b1;
    if (limit != 0 && cycle >= limit) begin
      $display("timeout: run did not end within %0d cycles, test %s", limit, test_name);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    int idle;
    idle = $urandom % 4;  // random spacing between host bytes
    repeat (idle) @(negedge clk_i);
    byte_i     = b;
    byte_stb_i = 1'b1;
    @(negedge clk_i);
    byte_stb_i = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic finish_test();
    int waited;
    int k;
    waited = 0;
    while (got_q.size() - base < exp_q.size() && waited < 400) begin
      @(negedge clk_i);
      waited++;
    end
    repeat (20) @(negedge clk_i);  // catch extra words
    if (got_q.size() - base < exp_q.size()) begin
      $display("test %s: only %0d of %0d words arrived", test_name, got_q.size() - base,
               exp_q.size());
      test_errs++;
    end else if (got_q.size() - base > exp_q.size()) begin
      $display("test %s: %0d words more than expected", test_name,
               got_q.size() - base - exp_q.size());
      test_errs++;
    end
    for (k = 0; k < exp_q.size() && base + k < got_q.size(); k++) begin
      check_value("word", exp_q[k], got_q[base + k]);
      if (gap_exp != 0 && k > 0) begin
        check_value("gap", gap_exp, got_cyc_q[base + k] - got_cyc_q[base + k - 1]);
      end
    end
    if (trig_exp >= 0) check_value("trig", trig_exp, trig_seen);
    check_value("armed", run_sent, armed_seen);
    check_value("armed at end", 1'b0, armed_o);  // capture disarms after its last sample
    n_tests++;
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, test_errs);
      n_failed++;
    end
    errors += test_errs;
  endtask

  task automatic run_golden(input int fd);
    string       kw;
    string       line;
    int          r;
    int          n;
    int          param_left;  // parameter bytes still owed by a long command
    int          xoff_base;   // word count when XOFF went out, -1 when not paused
    bit          is_opc;
    logic [31:0] val;
    param_left = 0;
    xoff_base  = -1;
    while ($fscanf(fd, "%s", kw) == 1) begin
      case (kw)
        "#": r = $fgets(line, fd);
        "test": begin
          r = $fscanf(fd, "%s", test_name);
          exp_q.delete();
          base       = got_q.size();
          gap_exp    = 0;
          trig_exp   = -1;
          trig_seen  = 1'b0;
          armed_seen = 1'b0;
          run_sent   = 1'b0;
          xoff_base  = -1;
          test_errs  = 0;
        end
        "probe": begin
          r = $fscanf(fd, "%h", val);
          probe_i = val;
        end
        "wait": begin
          r = $fscanf(fd, "%d", n);
          repeat (n) @(negedge clk_i);
        end
        "send": begin
          r = $fscanf(fd, "%d", n);
          repeat (n) begin
            r = $fscanf(fd, "%h", val);
            is_opc = (param_left == 0);
            if (is_opc && val[7:0] == sump_pkg::XON && xoff_base >= 0) begin
              check_value("words during xoff", xoff_base, got_q.size());
              xoff_base = -1;
            end
            send_byte(val[7:0]);
            if (!is_opc) begin
              param_left--;
            end else if (val[7]) begin
              param_left = 4;
            end else if (val[7:0] == sump_pkg::RUN) begin
              run_sent = 1'b1;
            end else if (val[7:0] == sump_pkg::XOFF) begin
              xoff_base = got_q.size();
            end
          end
        end
        "expect": begin
          r = $fscanf(fd, "%d %h", n, val);
          repeat (n) exp_q.push_back(val);
        end
        "gap":  r = $fscanf(fd, "%d", gap_exp);
        "trig": r = $fscanf(fd, "%d", trig_exp);
        "done": finish_test();
        default: begin
          $display("golden file holds an unknown keyword: %s", kw);
          errors++;
        end
      endcase
    end
  endtask

  initial begin : stimulus
    int    fd;
    int    r;
    int    lines;
    string line;
    rst_i      = 1'b1;
    byte_i     = 8'h00;
    byte_stb_i = 1'b0;
    probe_i    = '0;
    trig_prev  = 1'b0;
    r          = $urandom(32'hd2e1);
    lines      = 0;
    fd = $fopen("bench/sump_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/sump_golden.txt");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        r = $fgets(line, fd);
        if (r > 0) lines++;
      end
      $fclose(fd);
      limit = 200 + 64 * lines;
      fd = $fopen("bench/sump_golden.txt", "r");
      repeat (2) @(negedge clk_i);
      rst_i = 1'b0;
      run_golden(fd);
      $fclose(fd);
      $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
      if (errors == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

// File: bench/sump_golden.txt
# test <name> | probe <hex> | wait <cycles> | send <n> <n hex bytes>
# expect <n> <hex word> | gap <cycles between words> | trig <0 or 1> | done
test id_word
send 1 02
expect 1 534C4131
done
test default_run
probe 00A55A01
send 1 01
expect 4 00A55A01
gap 1
trig 1
done
test masked_trigger
probe 00000000
send 5 C0 00 00 FF FF
send 5 C1 00 00 34 12
send 5 81 02 00 00 00
send 1 01
wait 20
probe 1234ABCD
expect 3 1234ABCD
trig 1
done
test divided_rate
send 5 80 03 00 00 00
send 1 01
expect 3 1234ABCD
gap 4
done
test xoff_xon
probe 1234BEEF
send 5 81 07 00 00 00
send 1 01
wait 10
send 1 13
wait 30
send 1 11
expect 8 1234BEEF
done
test stage_ignored
probe 12340042
send 5 C4 FF FF FF FF
send 5 C5 00 00 00 00
send 1 01
expect 8 12340042
done
test soft_reset
probe CAFEF00D
send 2 00 01
expect 4 CAFEF00D
gap 1
done

// File: hw/sump_capture.sv
`timescale 1ns/1ps
module sump_capture (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       sft_rst_i,
  input  logic                       arm_i,
  input  logic                       id_i,
  input  logic                       xon_i,
  input  logic                       xoff_i,
  input  logic                       tick_i,
  input  logic [sump_pkg::SMP_W-1:0] probe_i,
  input  logic [sump_pkg::SMP_W-1:0] trg_mask_i,
  input  logic [sump_pkg::SMP_W-1:0] trg_val_i,
  input  logic [sump_pkg::CNT_W-1:0] cnt_i,
  output logic                       run_o,
  output logic                       armed_o,
  output logic                       trig_o,
  output logic [sump_pkg::SMP_W-1:0] dat_o,
  output logic                       vld_o
);

  logic                       armed_q;
  logic                       trig_q;
  logic                       paused_q;   // XOFF received
  logic                       id_pend_q;  // ID waiting for a free slot
  logic [sump_pkg::CNT_W-1:0] rem_q;      // samples still to send
  logic                       take;
  logic                       match;
  logic                       hit;
  logic                       emit_id;

  assign run_o   = armed_q & ~paused_q;
  assign armed_o = armed_q;
  assign trig_o  = trig_q;

  // a tick racing a pause, rearm or soft reset is dropped
  assign take    = tick_i & run_o & ~xoff_i & ~arm_i & ~sft_rst_i;
  assign match   = ((probe_i ^ trg_val_i) & trg_mask_i) == '0;
  assign hit     = take & (trig_q | match);
  assign emit_id = (id_pend_q | id_i) & ~paused_q & ~xoff_i & ~hit;

  always_ff @(posedge clk_i) begin : ctrl
    if (rst_i || sft_rst_i) begin
      armed_q   <= 1'b0;
      trig_q    <= 1'b0;
      paused_q  <= 1'b0;
      id_pend_q <= 1'b0;
      rem_q     <= '0;
      vld_o     <= 1'b0;
    end else begin
      vld_o <= hit | emit_id;
      if (xoff_i) begin
        paused_q <= 1'b1;
      end else if (xon_i) begin
        paused_q <= 1'b0;
      end
      if (emit_id) begin
        id_pend_q <= 1'b0;
      end else if (id_i) begin
        id_pend_q <= 1'b1;  // held until the stream is free
      end
      if (arm_i) begin
        armed_q <= 1'b1;
        trig_q  <= 1'b0;
      end else if (hit) begin
        if (!trig_q) begin  // trigger sample is the first one out
          trig_q <= 1'b1;
          rem_q  <= cnt_i;
          if (cnt_i == '0) armed_q <= 1'b0;
        end else begin
          rem_q <= rem_q - 1'b1;
          if (rem_q == 1) armed_q <= 1'b0;  // last sample
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : data
    if (hit) begin
      dat_o <= probe_i;
    end else if (emit_id) begin
      dat_o <= sump_pkg::ID_WORD;
    end
  end

  a_no_vld_paused : assert property (
    @(posedge clk_i) disable iff (rst_i)
    paused_q |-> !vld_o
  );

endmodule

// File: hw/sump_cfg_regs.sv
`timescale 1ns/1ps
module sump_cfg_regs (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         sft_rst_i,
  input  logic                         set_mask_i,
  input  logic                         set_val_i,
  input  logic                         set_div_i,
  input  logic                         set_cnt_i,
  input  logic [1:0]                   stg_i,
  input  logic [sump_pkg::PARAM_W-1:0] param_i,
  output logic [sump_pkg::SMP_W-1:0]   trg_mask_o,
  output logic [sump_pkg::SMP_W-1:0]   trg_val_o,
  output logic [sump_pkg::DIV_W-1:0]   div_o,
  output logic [sump_pkg::CNT_W-1:0]   cnt_o
);

  logic stg0;  // only stage 0 is implemented

  assign stg0 = (stg_i == 2'd0);

  always_ff @(posedge clk_i) begin : regs
    if (rst_i || sft_rst_i) begin
      trg_mask_o <= '0;  // zero mask triggers on first tick
      trg_val_o  <= '0;
      div_o      <= sump_pkg::DEF_DIV;
      cnt_o      <= sump_pkg::DEF_CNT;
    end else begin
      if (set_mask_i && stg0) begin
        trg_mask_o <= param_i[sump_pkg::SMP_W-1:0];
      end
      if (set_val_i && stg0) begin
        trg_val_o <= param_i[sump_pkg::SMP_W-1:0];
      end
      if (set_div_i) begin
        div_o <= param_i[sump_pkg::DIV_W-1:0];  // low 24 bits
      end
      if (set_cnt_i) begin
        cnt_o <= param_i[sump_pkg::CNT_W-1:0];  // read count only, no delay half
      end
    end
  end

endmodule

// File: hw/sump_cmd_fsm.sv
`timescale 1ns/1ps
module sump_cmd_fsm (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [7:0]                   byte_i,
  input  logic                         byte_stb_i,
  output logic                         cmd_stb_o,
  output sump_pkg::opcode_t            cmd_opc_o,
  output logic [sump_pkg::PARAM_W-1:0] cmd_param_o
);

  typedef enum logic {
    S_IDLE,   // waiting for an opcode
    S_PARAM   // collecting parameter bytes 0..3
  } state_t;

  state_t     state_q;
  logic [1:0] idx_q;  // parameter byte index

  always_ff @(posedge clk_i) begin : fsm
    if (rst_i) begin
      state_q   <= S_IDLE;
      idx_q     <= 2'd0;
      cmd_stb_o <= 1'b0;
    end else begin
      cmd_stb_o <= 1'b0;  // single cycle strobe
      if (byte_stb_i) begin
        case (state_q)
          S_IDLE: begin
            if (byte_i[7]) begin  // long command follows
              state_q <= S_PARAM;
              idx_q   <= 2'd0;
            end else begin
              cmd_stb_o <= 1'b1;  // short command complete
            end
          end
          S_PARAM: begin
            idx_q <= idx_q + 2'd1;
            if (idx_q == 2'd3) begin
              state_q   <= S_IDLE;
              cmd_stb_o <= 1'b1;
            end
          end
          default: state_q <= S_IDLE;
        endcase
      end
    end
  end

  // parameter bytes shift in from the top so the first one ends at the bottom
  always_ff @(posedge clk_i) begin : gather
    if (byte_stb_i) begin
      if (state_q == S_IDLE) begin
        cmd_opc_o <= sump_pkg::opcode_t'(byte_i);
      end else begin
        cmd_param_o <= {byte_i, cmd_param_o[sump_pkg::PARAM_W-1:8]};
      end
    end
  end

  // a command always needs at least one more byte strobe before the next one
  a_stb_single : assert property (
    @(posedge clk_i) disable iff (rst_i)
    cmd_stb_o |=> !cmd_stb_o
  );

endmodule

// File: hw/sump_ctrl.sv
`timescale 1ns/1ps
module sump_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [7:0]                 byte_i,
  input  logic                       byte_stb_i,
  input  logic [sump_pkg::SMP_W-1:0] probe_i,
  output logic [sump_pkg::SMP_W-1:0] dat_o,
  output logic                       vld_o,
  output logic                       armed_o,
  output logic                       trig_o
);

  logic                         cmd_stb;
  sump_pkg::opcode_t            cmd_opc;
  logic [sump_pkg::PARAM_W-1:0] cmd_param;

  logic       sft_rst, arm, id, xon, xoff;
  logic       set_mask, set_val, set_div, set_cnt;
  logic [1:0] stg;

  logic [sump_pkg::SMP_W-1:0] trg_mask;
  logic [sump_pkg::SMP_W-1:0] trg_val;
  logic [sump_pkg::DIV_W-1:0] div;
  logic [sump_pkg::CNT_W-1:0] cnt;
  logic                       run;
  logic                       tick;

  sump_cmd_fsm sump_cmd_fsm_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .byte_i      (byte_i),
    .byte_stb_i  (byte_stb_i),
    .cmd_stb_o   (cmd_stb),
    .cmd_opc_o   (cmd_opc),
    .cmd_param_o (cmd_param)
  );

  sump_indec sump_indec_i (
    .clk_i      (clk_i),
    .stb_i      (cmd_stb),
    .opc_i      (cmd_opc),
    .sft_rst_o  (sft_rst),
    .arm_o      (arm),
    .id_o       (id),
    .xon_o      (xon),
    .xoff_o     (xoff),
    .set_mask_o (set_mask),
    .set_val_o  (set_val),
    .set_cfg_o  (),          // trigger config not implemented
    .set_div_o  (set_div),
    .set_cnt_o  (set_cnt),
    .set_flgs_o (),          // flags have no effect
    .stg_o      (stg)
  );

  sump_cfg_regs sump_cfg_regs_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .sft_rst_i  (sft_rst),
    .set_mask_i (set_mask),
    .set_val_i  (set_val),
    .set_div_i  (set_div),
    .set_cnt_i  (set_cnt),
    .stg_i      (stg),
    .param_i    (cmd_param),
    .trg_mask_o (trg_mask),
    .trg_val_o  (trg_val),
    .div_o      (div),
    .cnt_o      (cnt)
  );

  sump_rate_timer sump_rate_timer_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .run_i  (run),
    .div_i  (div),
    .tick_o (tick)
  );

  sump_capture sump_capture_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .sft_rst_i  (sft_rst),
    .arm_i      (arm),
    .id_i       (id),
    .xon_i      (xon),
    .xoff_i     (xoff),
    .tick_i     (tick),
    .probe_i    (probe_i),
    .trg_mask_i (trg_mask),
    .trg_val_i  (trg_val),
    .cnt_i      (cnt),
    .run_o      (run),
    .armed_o    (armed_o),
    .trig_o     (trig_o),
    .dat_o      (dat_o),
    .vld_o      (vld_o)
  );

endmodule

// File: hw/sump_indec.sv
`timescale 1ns/1ps
module sump_indec (
  input  logic              clk_i,
  input  logic              stb_i,       // command valid
  input  sump_pkg::opcode_t opc_i,
  output logic              sft_rst_o,
  output logic              arm_o,       // RUN
  output logic              id_o,
  output logic              xon_o,
  output logic              xoff_o,
  output logic              set_mask_o,
  output logic              set_val_o,
  output logic              set_cfg_o,
  output logic              set_div_o,
  output logic              set_cnt_o,
  output logic              set_flgs_o,
  output logic [1:0]        stg_o        // trigger stage
);

  logic [7:0] opc_raw;
  logic [7:0] opc_key;  // opcode with stage bits cleared for trigger group

  assign opc_raw = opc_i;
  assign opc_key = (opc_raw[7:6] == 2'b11) ? (opc_raw & ~sump_pkg::STG_BITS) : opc_raw;
  assign stg_o   = stb_i ? opc_raw[3:2] : 2'b00;

  always_comb begin : decode
    sft_rst_o  = 1'b0;
    arm_o      = 1'b0;
    id_o       = 1'b0;
    xon_o      = 1'b0;
    xoff_o     = 1'b0;
    set_mask_o = 1'b0;
    set_val_o  = 1'b0;
    set_cfg_o  = 1'b0;
    set_div_o  = 1'b0;
    set_cnt_o  = 1'b0;
    set_flgs_o = 1'b0;
    if (stb_i) begin
      case (opc_key)
        sump_pkg::SOFT_RESET:     sft_rst_o  = 1'b1;
        sump_pkg::RUN:            arm_o      = 1'b1;
        sump_pkg::ID:             id_o       = 1'b1;
        sump_pkg::XON:            xon_o      = 1'b1;
        sump_pkg::XOFF:           xoff_o     = 1'b1;
        sump_pkg::SET_TRG_MSK:    set_mask_o = 1'b1;
        sump_pkg::SET_TRG_VAL:    set_val_o  = 1'b1;
        sump_pkg::SET_TRG_CONF:   set_cfg_o  = 1'b1;
        sump_pkg::SET_DIV:        set_div_o  = 1'b1;
        sump_pkg::SET_RD_DLY_CNT: set_cnt_o  = 1'b1;
        sump_pkg::SET_FLAGS:      set_flgs_o = 1'b1;
        default: ;  // unknown opcodes are dropped
      endcase
    end
  end

  a_cmd_onehot : assert property (
    @(posedge clk_i)
    $onehot0({sft_rst_o, arm_o, id_o, xon_o, xoff_o, set_mask_o,
              set_val_o, set_cfg_o, set_div_o, set_cnt_o, set_flgs_o})
  );

endmodule

// File: hw/sump_pkg.sv
package sump_pkg;

  localparam int SMP_W   = 32;  // probe and sample width
  localparam int PARAM_W = 32;  // long command parameter
  localparam int DIV_W   = 24;  // divider field of SET_DIV
  localparam int CNT_W   = 16;  // read count field of SET_RD_DLY_CNT

  localparam logic [SMP_W-1:0] ID_WORD = 32'h534C_4131;  // "1ALS"
  localparam logic [DIV_W-1:0] DEF_DIV = '0;             // one tick per cycle
  localparam logic [CNT_W-1:0] DEF_CNT = 16'd3;          // four samples

  // stage select bits of the trigger commands
  localparam logic [7:0] STG_BITS = 8'h0C;

  typedef enum logic [7:0] {
    // short commands
    SOFT_RESET     = 8'h00,
    RUN            = 8'h01,
    ID             = 8'h02,
    XON            = 8'h11,
    XOFF           = 8'h13,
    // long commands with the trigger group in stage 0 encoding
    SET_TRG_MSK    = 8'hC0,
    SET_TRG_VAL    = 8'hC1,
    SET_TRG_CONF   = 8'hC2,
    SET_DIV        = 8'h80,
    SET_RD_DLY_CNT = 8'h81,
    SET_FLAGS      = 8'h82
  } opcode_t;

endpackage

// File: hw/sump_rate_timer.sv
`timescale 1ns/1ps
module sump_rate_timer (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       run_i,
  input  logic [sump_pkg::DIV_W-1:0] div_i,
  output logic                       tick_o
);

  logic [sump_pkg::DIV_W-1:0] cnt_q;  // cycles left until next tick

  // one tick every div_i+1 cycles while running
  always_ff @(posedge clk_i) begin : count
    if (rst_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (!run_i) begin
      cnt_q  <= div_i;  // restart from a full interval
      tick_o <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q  <= div_i;
      tick_o <= 1'b1;
    end else begin
      cnt_q  <= cnt_q - 1'b1;
      tick_o <= 1'b0;
    end
  end

endmodule

// File: sump_ctrl.f
hw/sump_pkg.sv
hw/sump_cmd_fsm.sv
hw/sump_indec.sv
hw/sump_cfg_regs.sv
hw/sump_rate_timer.sv
hw/sump_capture.sv
hw/sump_ctrl.sv
bench/sump_ctrl_tb.sv
